/* legalizer_top.f */
+incdir+.
legalizer_pkg.sv
chan_ctrl_if.sv
page_splitter.sv
burst_chan.sv
rw_coordinator.sv
legalizer_top.sv
tb_legalizer_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the legalizer testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f legalizer_top.f --top-module tb_legalizer_top -o sim_legalizer

./obj_dir/sim_legalizer | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* tb_checks.svh */
// Error counters, compare tasks and failure reporting for the legalizer testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Wrong values seen on DUT outputs
int mismatch_count = 0;
// Lost, extra or late bursts and other flow failures
int failure_count = 0;

task automatic check_addr(input string name, input legalizer_pkg::addr_t got,
                          input legalizer_pkg::addr_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_beats(input string name, input legalizer_pkg::beats_t got,
                           input legalizer_pkg::beats_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// Also used for the tailer
task automatic check_offset(input string name, input legalizer_pkg::offset_t got,
                            input legalizer_pkg::offset_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic report_failure(input string what);
    failure_count++;
    $display("ERROR %s at %0t", what, $time);
endtask

`endif

/* tb_legalizer_top.sv */
// Legalizer testbench: clock, reset, stimulus table, reference model, monitor and watchdog
`timescale 1ns/100ps

module tb_legalizer_top;

    `include "tb_checks.svh"

    localparam int NUM_ROWS       = 12;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 400;

    // One expected burst on either side
    typedef struct packed {
        legalizer_pkg::addr_t   addr;
        legalizer_pkg::beats_t  beats;
        legalizer_pkg::offset_t offset;
        legalizer_pkg::offset_t tailer;
        logic                   last;
    } burst_t;

    // One copy request of the stimulus table
    typedef struct packed {
        legalizer_pkg::len_t  length;
        legalizer_pkg::addr_t src;
        legalizer_pkg::addr_t dst;
        logic                 decouple;
        logic                 src_reduce;
        logic                 dst_reduce;
        legalizer_pkg::llen_t src_llen;
        legalizer_pkg::llen_t dst_llen;
        logic [7:0]           kill_cycle;
    } row_t;

    logic                   clk_i = 1'b0;
    logic                   reset_i;
    logic                   valid_i;
    legalizer_pkg::len_t    length_i;
    legalizer_pkg::addr_t   src_addr_i;
    legalizer_pkg::addr_t   dst_addr_i;
    logic                   decouple_rw_i;
    logic                   src_reduce_len_i;
    logic                   dst_reduce_len_i;
    legalizer_pkg::llen_t   src_max_llen_i;
    legalizer_pkg::llen_t   dst_max_llen_i;
    logic                   r_ready_i;
    logic                   w_ready_i;
    logic                   flush_i;
    logic                   kill_i;
    logic                   ready_o;
    logic                   r_valid_o;
    legalizer_pkg::addr_t   r_addr_o;
    legalizer_pkg::beats_t  r_len_o;
    legalizer_pkg::offset_t r_offset_o;
    legalizer_pkg::offset_t r_tailer_o;
    logic                   w_valid_o;
    legalizer_pkg::addr_t   w_addr_o;
    legalizer_pkg::beats_t  w_len_o;
    legalizer_pkg::offset_t w_offset_o;
    legalizer_pkg::offset_t w_tailer_o;
    logic                   w_last_o;
    logic                   r_busy_o;
    logic                   w_busy_o;

    // Expected bursts, oldest first
    burst_t exp_r[$];
    burst_t exp_w[$];
    row_t   rows [NUM_ROWS];
    int     seed = 75;
    int     cur_row = 0;
    logic   accepted;

    always #5 clk_i = ~clk_i;

    legalizer_top i_legalizer_top (
        .clk_i (clk_i), .reset_i (reset_i), .valid_i (valid_i), .length_i (length_i),
        .src_addr_i (src_addr_i), .dst_addr_i (dst_addr_i), .decouple_rw_i (decouple_rw_i),
        .src_reduce_len_i (src_reduce_len_i), .dst_reduce_len_i (dst_reduce_len_i),
        .src_max_llen_i (src_max_llen_i), .dst_max_llen_i (dst_max_llen_i),
        .ready_o (ready_o), .r_valid_o (r_valid_o), .r_addr_o (r_addr_o), .r_len_o (r_len_o),
        .r_offset_o (r_offset_o), .r_tailer_o (r_tailer_o), .r_ready_i (r_ready_i),
        .w_valid_o (w_valid_o), .w_addr_o (w_addr_o), .w_len_o (w_len_o),
        .w_offset_o (w_offset_o), .w_tailer_o (w_tailer_o), .w_last_o (w_last_o),
        .w_ready_i (w_ready_i), .flush_i (flush_i), .kill_i (kill_i),
        .r_busy_o (r_busy_o), .w_busy_o (w_busy_o)
    );

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------

    task automatic load_table();
        // length, src, dst, decouple, src/dst reduce, src/dst llen, kill cycle
        rows[0]  = '{24'd3000, 24'h0003F0, 24'h000102, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
        rows[1]  = '{24'd2500, 24'h001201, 24'h0023FE, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
        rows[2]  = '{24'd2048, 24'h000350, 24'h0041FD, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
        rows[3]  = '{24'd700,  24'h0007FF, 24'h000C00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
        rows[4]  = '{24'd100,  24'h000013, 24'h000020, 1'b0, 1'b1, 1'b1, 3'd2, 3'd2, 8'd0};
        rows[5]  = '{24'd900,  24'h000105, 24'h0003A2, 1'b1, 1'b1, 1'b1, 3'd4, 3'd6, 8'd0};
        rows[6]  = '{24'd1500, 24'h000601, 24'h000FF3, 1'b0, 1'b1, 1'b0, 3'd7, 3'd0, 8'd0};
        // Killed mid-transfer
        rows[7]  = '{24'd4000, 24'h000000, 24'h000802, 1'b1, 1'b0, 1'b0, 3'd0, 3'd0, 8'd3};
        rows[8]  = '{24'd37,   24'h0013FE, 24'h0017FD, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
        rows[9]  = '{24'd2000, 24'h000010, 24'h000031, 1'b0, 1'b1, 1'b1, 3'd3, 3'd3, 8'd5};
        // One beat per burst on the write side
        rows[10] = '{24'd23,   24'h000100, 24'h000203, 1'b1, 1'b0, 1'b1, 3'd0, 3'd0, 8'd0};
        rows[11] = '{24'd1,    24'h000003, 24'h000001, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'd0};
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic int unsigned min_of(input int unsigned a, input int unsigned b);
        return (a < b) ? a : b;
    endfunction

    // Bytes left before the page end or the beat-limit window end
    function automatic int unsigned boundary_dist(input int unsigned addr, input logic reduce,
                                                  input int unsigned llen);
        int unsigned win;
        win = legalizer_pkg::PAGE_SIZE;
        if (reduce && ((legalizer_pkg::STRB_WIDTH << llen) < win)) begin
            win = legalizer_pkg::STRB_WIDTH << llen;
        end
        return win - (addr % win);
    endfunction

    function automatic burst_t make_burst(input int unsigned addr, input int unsigned bytes,
                                          input logic last);
        burst_t      b;
        int unsigned offs;
        offs     = addr % legalizer_pkg::STRB_WIDTH;
        b.addr   = legalizer_pkg::addr_t'(addr - offs);
        b.beats  = legalizer_pkg::beats_t'((bytes + offs - 1) / legalizer_pkg::STRB_WIDTH);
        b.offset = legalizer_pkg::offset_t'(offs);
        b.tailer = legalizer_pkg::offset_t'((bytes + offs) % legalizer_pkg::STRB_WIDTH);
        b.last   = last;
        return b;
    endfunction

    // Cut one row into both burst queues
    task automatic expect_row(input int idx);
        row_t        row;
        int unsigned r_addr;
        int unsigned w_addr;
        int unsigned r_left;
        int unsigned w_left;
        int unsigned r_step;
        int unsigned w_step;
        row    = rows[idx];
        r_addr = row.src;
        w_addr = row.dst;
        r_left = row.length;
        w_left = row.length;
        while ((r_left != 0) || (w_left != 0)) begin
            r_step = min_of(r_left, boundary_dist(r_addr, row.src_reduce, row.src_llen));
            w_step = min_of(w_left, boundary_dist(w_addr, row.dst_reduce, row.dst_llen));
            // Coupled sides share the nearer cut
            if (!row.decouple) begin
                r_step = min_of(r_step, w_step);
                w_step = r_step;
            end
            if (r_step != 0) begin
                exp_r.push_back(make_burst(r_addr, r_step, r_step == r_left));
                r_addr += r_step;
                r_left -= r_step;
            end
            if (w_step != 0) begin
                exp_w.push_back(make_burst(w_addr, w_step, w_step == w_left));
                w_addr += w_step;
                w_left -= w_step;
            end
        end
    endtask

    // ----------------------------------------------------------
    // Monitor, samples on the rising edge
    // ----------------------------------------------------------

    task automatic compare_read();
        burst_t b;
        if (exp_r.size() == 0) begin
            report_failure("read burst issued while no read burst was expected");
        end else begin
            b = exp_r.pop_front();
            check_addr("r_addr_o", r_addr_o, b.addr);
            check_beats("r_len_o", r_len_o, b.beats);
            check_offset("r_offset_o", r_offset_o, b.offset);
            check_offset("r_tailer_o", r_tailer_o, b.tailer);
        end
    endtask

    task automatic compare_write();
        burst_t b;
        if (exp_w.size() == 0) begin
            report_failure("write burst issued while no write burst was expected");
        end else begin
            b = exp_w.pop_front();
            check_addr("w_addr_o", w_addr_o, b.addr);
            check_beats("w_len_o", w_len_o, b.beats);
            check_offset("w_offset_o", w_offset_o, b.offset);
            check_offset("w_tailer_o", w_tailer_o, b.tailer);
            check_flag("w_last_o", w_last_o, b.last);
        end
    endtask

    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (r_valid_o) begin
                compare_read();
            end
            if (w_valid_o) begin
                compare_write();
            end
            // Both sides done means nothing of the row is left
            if (ready_o && ((exp_r.size() != 0) || (exp_w.size() != 0))) begin
                report_failure("ready_o high while bursts of the transfer are outstanding");
            end
            if (valid_i && ready_o) begin
                expect_row(cur_row);
            end
        end
    end

    // ----------------------------------------------------------
    // Driver, falling edge
    // ----------------------------------------------------------

    // Random readies, short flush windows
    task automatic step_cycle();
        @(negedge clk_i);
        r_ready_i = ($random(seed) & 3) != 0;
        w_ready_i = ($random(seed) & 3) != 0;
        flush_i   = ($random(seed) & 15) == 0;
    endtask

    task automatic present_row(input int idx);
        cur_row          = idx;
        valid_i          = 1'b1;
        length_i         = rows[idx].length;
        src_addr_i       = rows[idx].src;
        dst_addr_i       = rows[idx].dst;
        decouple_rw_i    = rows[idx].decouple;
        src_reduce_len_i = rows[idx].src_reduce;
        dst_reduce_len_i = rows[idx].dst_reduce;
        src_max_llen_i   = rows[idx].src_llen;
        dst_max_llen_i   = rows[idx].dst_llen;
    endtask

    task automatic kill_transfer();
        @(negedge clk_i);
        kill_i    = 1'b1;
        r_ready_i = 1'b0;
        w_ready_i = 1'b0;
        flush_i   = 1'b0;
        @(negedge clk_i);
        check_flag("r_busy_o", r_busy_o, 1'b0);
        check_flag("w_busy_o", w_busy_o, 1'b0);
        kill_i = 1'b0;
        // Rest of the row never comes out
        exp_r.delete();
        exp_w.delete();
    endtask

    initial begin
        load_table();
        reset_i = 1'b1;
        valid_i = 1'b0;
        present_row(0);
        valid_i   = 1'b0;
        r_ready_i = 1'b0;
        w_ready_i = 1'b0;
        flush_i   = 1'b0;
        kill_i    = 1'b0;
        repeat (8) @(negedge clk_i);
        reset_i   = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;

        // Idle after reset, done sides leave ready_o on the readies
        repeat (3) begin
            @(posedge clk_i);
            check_flag("r_valid_o", r_valid_o, 1'b0);
            check_flag("w_valid_o", w_valid_o, 1'b0);
            check_flag("r_busy_o", r_busy_o, 1'b0);
            check_flag("w_busy_o", w_busy_o, 1'b0);
            check_flag("ready_o", ready_o, 1'b1);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            step_cycle();
            present_row(i);
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk_i);
                accepted = ready_o;
                if (!accepted) begin
                    step_cycle();
                end
            end
            step_cycle();
            valid_i = 1'b0;
            if (rows[i].kill_cycle != 0) begin
                repeat (rows[i].kill_cycle - 1) step_cycle();
                kill_transfer();
            end else begin
                while ((exp_r.size() != 0) || (exp_w.size() != 0)) begin
                    step_cycle();
                end
            end
        end

        repeat (4) step_cycle();
        if ((exp_r.size() != 0) || (exp_w.size() != 0)) begin
            report_failure("expected bursts never appeared");
        end
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog, sized from the table length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        report_failure("watchdog timeout, transfers did not complete in time");
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* legalizer_top.sv */
// Burst legalizer top level: coordinator and read/write burst channels
`timescale 1ns/100ps

module legalizer_top (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // 1D copy request
    input  logic                    valid_i,
    input  legalizer_pkg::len_t     length_i,
    input  legalizer_pkg::addr_t    src_addr_i,
    input  legalizer_pkg::addr_t    dst_addr_i,
    input  logic                    decouple_rw_i,
    input  logic                    src_reduce_len_i,
    input  logic                    dst_reduce_len_i,
    input  legalizer_pkg::llen_t    src_max_llen_i,
    input  legalizer_pkg::llen_t    dst_max_llen_i,
    output logic                    ready_o,

    // Read burst stream
    output logic                    r_valid_o,
    output legalizer_pkg::addr_t    r_addr_o,
    output legalizer_pkg::beats_t   r_len_o,
    output legalizer_pkg::offset_t  r_offset_o,
    output legalizer_pkg::offset_t  r_tailer_o,
    input  logic                    r_ready_i,

    // Write burst stream
    output logic                    w_valid_o,
    output legalizer_pkg::addr_t    w_addr_o,
    output legalizer_pkg::beats_t   w_len_o,
    output legalizer_pkg::offset_t  w_offset_o,
    output legalizer_pkg::offset_t  w_tailer_o,
    output logic                    w_last_o,
    input  logic                    w_ready_i,

    // Control and status
    input  logic                    flush_i,
    input  logic                    kill_i,
    output logic                    r_busy_o,
    output logic                    w_busy_o
);

    // One control link per side
    chan_ctrl_if r_ctrl_if ();
    chan_ctrl_if w_ctrl_if ();

    // ----------------------------------------------------------
    // Flow coordinator
    // ----------------------------------------------------------

    rw_coordinator i_rw_coordinator (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .decouple_rw_i (decouple_rw_i),
        .r_ready_i     (r_ready_i),
        .w_ready_i     (w_ready_i),
        .flush_i       (flush_i),
        .kill_i        (kill_i),
        .ready_o       (ready_o),
        .r_valid_o     (r_valid_o),
        .w_valid_o     (w_valid_o),
        .busy_r_i      (r_busy_o),
        .busy_w_i      (w_busy_o),
        .r_ctrl        (r_ctrl_if.coord),
        .w_ctrl        (w_ctrl_if.coord)
    );

    // ----------------------------------------------------------
    // Read side, source address
    // ----------------------------------------------------------

    // Last flag only matters on the write side
    burst_chan i_read_chan (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_i       (src_addr_i),
        .length_i     (length_i),
        .reduce_len_i (src_reduce_len_i),
        .max_llen_i   (src_max_llen_i),
        .ctrl         (r_ctrl_if.chan),
        .busy_o       (r_busy_o),
        .addr_o       (r_addr_o),
        .len_o        (r_len_o),
        .offset_o     (r_offset_o),
        .tailer_o     (r_tailer_o),
        .last_o       ()
    );

    // ----------------------------------------------------------
    // Write side, destination address
    // ----------------------------------------------------------

    burst_chan i_write_chan (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_i       (dst_addr_i),
        .length_i     (length_i),
        .reduce_len_i (dst_reduce_len_i),
        .max_llen_i   (dst_max_llen_i),
        .ctrl         (w_ctrl_if.chan),
        .busy_o       (w_busy_o),
        .addr_o       (w_addr_o),
        .len_o        (w_len_o),
        .offset_o     (w_offset_o),
        .tailer_o     (w_tailer_o),
        .last_o       (w_last_o)
    );

endmodule

/* rw_coordinator.sv */
// Read/write coordinator with option register, byte limits, enables, valids and request ready
`timescale 1ns/100ps

module rw_coordinator (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        valid_i,
    input  logic        decouple_rw_i,
    input  logic        r_ready_i,
    input  logic        w_ready_i,
    input  logic        flush_i,
    input  logic        kill_i,
    output logic        ready_o,
    output logic        r_valid_o,
    output logic        w_valid_o,
    input  logic        busy_r_i,
    input  logic        busy_w_i,
    chan_ctrl_if.coord  r_ctrl,
    chan_ctrl_if.coord  w_ctrl
);

    // Option of the transfer in flight
    logic decouple_q;
    // Request taken this cycle
    logic load;
    // Nearer boundary of the two sides
    legalizer_pkg::page_len_t c_bytes_to_pb;
    // Side allowed to move by its readies
    logic r_go;
    logic w_go;

    // ----------------------------------------------------------
    // Option register
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decouple_q <= 1'b0;
        end else if (load) begin
            decouple_q <= decouple_rw_i;
        end
    end

    // ----------------------------------------------------------
    // Byte limits
    // ----------------------------------------------------------

    assign c_bytes_to_pb = (r_ctrl.bytes_to_pb > w_ctrl.bytes_to_pb) ?
                           w_ctrl.bytes_to_pb : r_ctrl.bytes_to_pb;

    // Coupled sides share one burst size
    assign r_ctrl.bytes_possible = decouple_q ? r_ctrl.bytes_to_pb : c_bytes_to_pb;
    assign w_ctrl.bytes_possible = decouple_q ? w_ctrl.bytes_to_pb : c_bytes_to_pb;

    // ----------------------------------------------------------
    // Flow control
    // ----------------------------------------------------------

    // Own ready plus the other ready when coupled
    assign r_go = r_ready_i && (decouple_q || w_ready_i);
    assign w_go = w_ready_i && (decouple_q || r_ready_i);

    // Kill forces a state update on both sides
    assign r_ctrl.ena = (r_go && !flush_i) || kill_i;
    assign w_ctrl.ena = (w_go && !flush_i) || kill_i;
    assign r_ctrl.kill = kill_i;
    assign w_ctrl.kill = kill_i;

    assign r_valid_o = busy_r_i && r_go && !flush_i;
    assign w_valid_o = busy_w_i && w_go && !flush_i;

    // Next request once both sides finish
    assign ready_o = r_ctrl.done && w_ctrl.done && r_ready_i && w_ready_i && !flush_i;
    assign load    = valid_i && ready_o;
    assign r_ctrl.load = load;
    assign w_ctrl.load = load;

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------

    // Ready without a new request leaves both channels idle next cycle
    a_ready_when_done: assert property (@(posedge clk_i) disable iff (reset_i)
        (ready_o && !valid_i && !kill_i) |=> (!busy_r_i && !busy_w_i));

endmodule

/* burst_chan.sv */
// Burst channel: mutable transfer state, burst cutting and AXI burst fields
`timescale 1ns/100ps

module burst_chan (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  legalizer_pkg::addr_t    addr_i,
    input  legalizer_pkg::len_t     length_i,
    input  logic                    reduce_len_i,
    input  legalizer_pkg::llen_t    max_llen_i,
    chan_ctrl_if.chan               ctrl,
    output logic                    busy_o,
    output legalizer_pkg::addr_t    addr_o,
    output legalizer_pkg::beats_t   len_o,
    output legalizer_pkg::offset_t  offset_o,
    output legalizer_pkg::offset_t  tailer_o,
    output logic                    last_o
);

    // Transfer state
    legalizer_pkg::addr_t     addr_q;
    legalizer_pkg::len_t      length_q;
    logic                     valid_q;
    logic                     reduce_len_q;
    legalizer_pkg::llen_t     max_llen_q;

    // Current burst
    legalizer_pkg::page_len_t num_bytes;
    logic                     fits;
    // Offset plus burst bytes, one bit of headroom
    logic [legalizer_pkg::PAGE_ADDR_WIDTH+1:0] span;

    // Boundary for the current address with the stored options
    page_splitter i_page_splitter (
        .addr_i        (addr_q),
        .reduce_len_i  (reduce_len_q),
        .max_llen_i    (max_llen_q),
        .bytes_to_pb_o (ctrl.bytes_to_pb)
    );

    // ----------------------------------------------------------
    // Burst cutting
    // ----------------------------------------------------------

    // Rest of the transfer fits under the granted limit
    assign fits = (length_q <= legalizer_pkg::len_t'(ctrl.bytes_possible));

    // Full limit, or whatever is left
    assign num_bytes = fits ? legalizer_pkg::page_len_t'(length_q) : ctrl.bytes_possible;

    // Kill also ends the transfer in this cycle
    assign ctrl.done = !valid_q || fits || ctrl.kill;

    // ----------------------------------------------------------
    // State
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q      <= 1'b0;
            length_q     <= '0;
            reduce_len_q <= 1'b0;
            max_llen_q   <= '0;
        end else if (ctrl.load) begin
            // New request, even over a kill
            valid_q      <= 1'b1;
            length_q     <= length_i;
            reduce_len_q <= reduce_len_i;
            max_llen_q   <= max_llen_i;
        end else if (ctrl.kill) begin
            valid_q      <= 1'b0;
            length_q     <= '0;
            reduce_len_q <= 1'b0;
            max_llen_q   <= '0;
        end else if (ctrl.ena && valid_q) begin
            if (fits) begin
                // Last burst goes out now
                valid_q <= 1'b0;
            end else begin
                length_q <= length_q - legalizer_pkg::len_t'(num_bytes);
            end
        end
    end

    // Address follows the issued bursts
    always_ff @(posedge clk_i) begin
        if (ctrl.load) begin
            addr_q <= addr_i;
        end else if (ctrl.ena && valid_q && !fits && !ctrl.kill) begin
            addr_q <= addr_q + legalizer_pkg::addr_t'(num_bytes);
        end
    end

    // ----------------------------------------------------------
    // AXI burst fields
    // ----------------------------------------------------------

    assign offset_o = addr_q[legalizer_pkg::OFFSET_WIDTH-1:0];
    assign span     = {1'b0, num_bytes} + offset_o;

    // Beat aligned start
    assign addr_o   = {addr_q[legalizer_pkg::ADDR_WIDTH-1:legalizer_pkg::OFFSET_WIDTH],
                       {legalizer_pkg::OFFSET_WIDTH{1'b0}}};
    assign len_o    = legalizer_pkg::beats_t'((span - 1'b1) >> legalizer_pkg::OFFSET_WIDTH);
    // Zero means the last beat is full
    assign tailer_o = legalizer_pkg::offset_t'(span);
    assign last_o   = ctrl.done;
    assign busy_o   = valid_q;

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------

    // Granted limit never lets a burst run past a page end
    a_no_page_cross: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_q |-> ({1'b0, addr_q[legalizer_pkg::PAGE_ADDR_WIDTH-1:0]} + num_bytes)
                    <= legalizer_pkg::PAGE_SIZE);

    // Beat count within the reduced limit
    a_llen_limit: assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_q && reduce_len_q) |-> ({1'b0, len_o} < (9'd1 << max_llen_q)));

endmodule

/* page_splitter.sv */
// Page splitter: distance from an address to the next legal burst boundary
`timescale 1ns/100ps

module page_splitter (
    input  legalizer_pkg::addr_t     addr_i,
    input  logic                     reduce_len_i,
    input  legalizer_pkg::llen_t     max_llen_i,
    output legalizer_pkg::page_len_t bytes_to_pb_o
);

    // Window set by the beat limit
    legalizer_pkg::page_len_t llen_window;
    // Window actually in force
    legalizer_pkg::page_len_t window;
    // Position of the address inside that window
    legalizer_pkg::page_len_t addr_in_window;

    // ----------------------------------------------------------
    // Window size
    // ----------------------------------------------------------

    // Bytes per beat times max beats
    assign llen_window = legalizer_pkg::page_len_t'(legalizer_pkg::STRB_WIDTH) << max_llen_i;

    // Page always applies, beat limit only when reduce is on
    always_comb begin
        window = legalizer_pkg::page_len_t'(legalizer_pkg::PAGE_SIZE);
        if (reduce_len_i && (llen_window < window)) begin
            window = llen_window;
        end
    end

    // ----------------------------------------------------------
    // Distance to boundary
    // ----------------------------------------------------------

    // Window is a power of two, so modulo is a mask
    assign addr_in_window = {1'b0, addr_i[legalizer_pkg::PAGE_ADDR_WIDTH-1:0]}
                          & (window - 1'b1);

    // Never zero, at least one byte is left before the boundary
    assign bytes_to_pb_o = window - addr_in_window;

endmodule

/* chan_ctrl_if.sv */
// Control interface between the flow coordinator and one burst channel
`timescale 1ns/100ps

interface chan_ctrl_if;

    // Channel to coordinator
    // Distance from the current address to the next legal boundary
    legalizer_pkg::page_len_t bytes_to_pb;
    // Remaining length fits this burst, or nothing in flight
    logic done;

    // Coordinator to channel
    // Byte limit of the current burst
    legalizer_pkg::page_len_t bytes_possible;
    // Advance state this cycle
    logic ena;
    // Take a new request this cycle
    logic load;
    // Drop the transfer in flight
    logic kill;

    modport coord (
        input  bytes_to_pb,
        input  done,
        output bytes_possible,
        output ena,
        output load,
        output kill
    );

    modport chan (
        output bytes_to_pb,
        output done,
        input  bytes_possible,
        input  ena,
        input  load,
        input  kill
    );

endinterface

/* legalizer_pkg.sv */
// Shared widths, page constants and scalar types of the burst legalizer
package legalizer_pkg;

    // ----------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------

    // Data bus width in bits
    localparam int unsigned DATA_WIDTH = 32;

    // Bytes per beat
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    // Byte offset bits inside one beat
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);

    // Byte address and transfer length
    localparam int unsigned ADDR_WIDTH = 24;
    localparam int unsigned LEN_WIDTH  = 24;

    // ----------------------------------------------------------
    // Page and burst limits
    // ----------------------------------------------------------

    // AXI bursts may not cross a 4 KiB boundary, 256 beats is tighter here
    localparam int unsigned PAGE_SIZE = 1024;

    // Address bits inside one page
    localparam int unsigned PAGE_ADDR_WIDTH = $clog2(PAGE_SIZE);

    // Width of the log2 max beats setting
    localparam int unsigned LLEN_WIDTH = 3;

    // AXI len field
    localparam int unsigned BEATS_WIDTH = 8;

    // ----------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------

    // Byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Remaining transfer length in bytes
    typedef logic [LEN_WIDTH-1:0] len_t;

    // Byte count up to and including one full page
    typedef logic [PAGE_ADDR_WIDTH:0] page_len_t;

    // Byte position inside a beat
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    // Beats minus one, as on AR/AW len
    typedef logic [BEATS_WIDTH-1:0] beats_t;

    // Log2 of max beats per burst
    typedef logic [LLEN_WIDTH-1:0] llen_t;

endpackage
